//--- build.f
source/frontend_pkg.sv
source/queue_enq_if.sv
source/pc_gen.sv
source/fetch_stage.sv
source/inst_queue.sv
source/frontend_top.sv
testbench/imem_model.sv
testbench/tb_frontend.sv

//--- run_sim.sh
#!/bin/sh
# build the fetch front end testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_frontend -o tb_frontend_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_frontend_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- source/fetch_stage.sv
module fetch_stage (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] pc,
    input  logic        flush,
    input  logic        imem_resp_valid,
    input  logic [31:0] imem_resp_data,
    output logic        advance,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    queue_enq_if.fetch  enq
);

    typedef logic [$clog2(frontend_pkg::max_outstanding + 1)-1:0] out_cnt_t;
    typedef logic [frontend_pkg::queue_count_width-1:0] free_cnt_t;

    out_cnt_t    inflight;    // every request still waiting, stale ones too.
    out_cnt_t    drop_count;  // responses still owed to requests made before a flush.
    out_cnt_t    rec_count;   // live requests with a recorded pc.
    out_cnt_t    push_idx;
    logic [31:0] rec_pc [frontend_pkg::max_outstanding];
    logic        issue;
    logic        resp_drop;
    logic        resp_keep;

    // issue only while each request in flight still has a queue slot waiting for it.
    assign issue = arst_n  // nothing goes out while in reset.
                && (inflight < out_cnt_t'(frontend_pkg::max_outstanding))
                && (enq.free_count > free_cnt_t'(inflight))
                && !flush;

    // responses are in order, so the stale ones are always the oldest.
    assign resp_drop = imem_resp_valid && (flush || drop_count != '0);
    assign resp_keep = imem_resp_valid && !resp_drop;

    // slot for the new record once the oldest one leaves this cycle.
    assign push_idx = rec_count - out_cnt_t'(resp_keep);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inflight <= '0;
        end else begin
            inflight <= inflight + out_cnt_t'(issue) - out_cnt_t'(imem_resp_valid);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            drop_count <= '0;
        end else if (flush) begin
            // whatever is still out after this cycle belongs to the old stream.
            drop_count <= inflight - out_cnt_t'(imem_resp_valid);
        end else if (resp_drop) begin
            drop_count <= drop_count - out_cnt_t'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rec_count <= '0;
        end else if (flush) begin
            rec_count <= '0;  // old records become the drop count.
        end else begin
            rec_count <= rec_count + out_cnt_t'(issue) - out_cnt_t'(resp_keep);
        end
    end

    // in-order pc record, oldest at index 0.
    always_ff @(posedge clk) begin
        if (resp_keep) begin
            for (int i = 0; i < frontend_pkg::max_outstanding - 1; i++) begin
                rec_pc[i] <= rec_pc[i + 1];
            end
        end
        if (issue) begin
            for (int i = 0; i < frontend_pkg::max_outstanding; i++) begin
                if (out_cnt_t'(i) == push_idx) begin
                    rec_pc[i] <= pc;
                end
            end
        end
    end

    assign imem_req  = issue;
    assign imem_addr = pc;
    assign advance   = issue;  // pc steps on the edge of each request.

    // good responses go straight into the queue in the cycle they arrive.
    assign enq.enq   = resp_keep;
    assign enq.entry = '{pc: rec_pc[0], inst: imem_resp_data};
    assign enq.flush = flush;

endmodule

//--- source/frontend_pkg.sv
package frontend_pkg;

    // first fetch address after reset.
    localparam logic [31:0] reset_vector = 32'h1eceb000;

    // instruction queue size and the width of its free-slot count (0 to 16).
    localparam int queue_depth = 16;
    localparam int queue_count_width = 5;

    localparam int max_outstanding = 2;  // memory requests in flight at once.

    // one fetched word together with the address it came from.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_entry_t;

endpackage

//--- source/frontend_top.sv
module frontend_top (
    input  logic        clk,
    input  logic        arst_n,

    // back end.
    input  logic        flush,
    input  logic [31:0] redirect_pc,
    input  logic        deq,
    output logic        inst_valid,
    output logic [31:0] inst_pc,
    output logic [31:0] inst_data,

    // instruction memory port.
    output logic        imem_req,
    output logic [31:0] imem_addr,
    input  logic        imem_resp_valid,
    input  logic [31:0] imem_resp_data
);

    logic [31:0]                pc;
    logic                       advance;
    frontend_pkg::fetch_entry_t head;

    queue_enq_if u_enq_if ();

    pc_gen u_pc_gen (
        .clk         (clk),
        .arst_n      (arst_n),
        .advance     (advance),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .pc          (pc)
    );

    fetch_stage u_fetch_stage (
        .clk             (clk),
        .arst_n          (arst_n),
        .pc              (pc),
        .flush           (flush),
        .imem_resp_valid (imem_resp_valid),
        .imem_resp_data  (imem_resp_data),
        .advance         (advance),
        .imem_req        (imem_req),
        .imem_addr       (imem_addr),
        .enq             (u_enq_if.fetch)
    );

    inst_queue u_inst_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .deq        (deq),
        .enq        (u_enq_if.queue),
        .head_valid (inst_valid),
        .head       (head)
    );

    // head entry out to the back end.
    assign inst_pc   = head.pc;
    assign inst_data = head.inst;

endmodule

//--- source/inst_queue.sv
module inst_queue (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       deq,
    queue_enq_if.queue                 enq,
    output logic                       head_valid,
    output frontend_pkg::fetch_entry_t head
);

    typedef logic [$clog2(frontend_pkg::queue_depth)-1:0] ptr_t;
    typedef logic [frontend_pkg::queue_count_width-1:0] cnt_t;

    frontend_pkg::fetch_entry_t mem [frontend_pkg::queue_depth];

    ptr_t rd_ptr;
    ptr_t wr_ptr;
    cnt_t count;
    logic do_deq;

    function automatic ptr_t ptr_inc(input ptr_t p);
        if (p == ptr_t'(frontend_pkg::queue_depth - 1)) begin
            return '0;
        end
        return p + ptr_t'(1);
    endfunction

    assign head_valid = count != '0;
    assign do_deq     = deq && head_valid;  // dequeue on an empty queue is ignored.
    assign head       = mem[rd_ptr];

    // free slots come straight from the occupancy count.
    assign enq.free_count = cnt_t'(frontend_pkg::queue_depth) - count;

    always_ff @(posedge clk) begin
        if (enq.enq) begin
            mem[wr_ptr] <= enq.entry;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (enq.flush) begin
            // flush empties the queue on this edge.
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq.enq) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_deq) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + cnt_t'(enq.enq) - cnt_t'(do_deq);  // both may happen at once.
        end
    end

endmodule

//--- source/pc_gen.sv
module pc_gen (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        advance,
    input  logic        flush,
    input  logic [31:0] redirect_pc,
    output logic [31:0] pc
);

    logic [31:0] pc_q;
    logic [31:0] pc_d;

    // a redirect always beats the sequential step.
    always_comb begin
        if (flush) begin
            pc_d = redirect_pc;
        end else if (advance) begin
            pc_d = pc_q + 32'd4;  // one word per request.
        end else begin
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= frontend_pkg::reset_vector;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc = pc_q;

endmodule

//--- source/queue_enq_if.sv
interface queue_enq_if;

    logic                                       enq;         // one-cycle write strobe.
    frontend_pkg::fetch_entry_t                 entry;
    logic [frontend_pkg::queue_count_width-1:0] free_count;
    logic                                       flush;       // clears the queue.

    modport fetch (
        output enq,
        output entry,
        output flush,
        input  free_count
    );

    modport queue (
        input  enq,
        input  entry,
        input  flush,
        output free_count
    );

endinterface

//--- testbench/imem_model.sv
module imem_model (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        req,
    input  logic [31:0] addr,
    output logic        resp_valid,
    output logic [31:0] resp_data
);

    logic [31:0] addr_q [$];  // accepted requests, oldest first.
    int          due_q [$];   // cycle in which each one is answered.
    int          cycle;
    int          last_due;

    initial begin
        resp_valid = 1'b0;
        resp_data  = '0;
        cycle      = 0;
        last_due   = 0;
    end

    // requests are taken at the rising edge, where the strobe has settled.
    always @(posedge clk or negedge arst_n) begin
        int due;
        if (!arst_n) begin
            addr_q.delete();
            due_q.delete();
            cycle    = 0;
            last_due = 0;
        end else begin
            if (req) begin
                due = cycle + 1 + int'($urandom % 6);  // 1 to 6 cycles.
                if (due <= last_due) begin
                    due = last_due + 1;  // keep request order, one answer per cycle.
                end
                addr_q.push_back(addr);
                due_q.push_back(due);
                last_due = due;
            end
            cycle = cycle + 1;
        end
    end

    // answers go out on the falling edge, like the rest of the stimulus.
    always @(negedge clk) begin
        if (arst_n && due_q.size() > 0 && due_q[0] == cycle) begin
            resp_valid <= 1'b1;
            resp_data  <= ~addr_q[0];  // data is the inverse of the address.
            void'(addr_q.pop_front());
            void'(due_q.pop_front());
        end else begin
            resp_valid <= 1'b0;
            resp_data  <= '0;
        end
    end

endmodule

//--- testbench/tb_frontend.sv
module tb_frontend;

    logic        clk;
    logic        arst_n;
    logic        flush;
    logic [31:0] redirect_pc;
    logic        deq;
    logic        inst_valid;
    logic [31:0] inst_pc;
    logic [31:0] inst_data;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_resp_valid;
    logic [31:0] imem_resp_data;

    int          errors;
    int          words_checked;
    int          flushes;
    logic [31:0] exp_pc;          // next pc the back end should see.
    int          outstanding;     // requests still without a response.
    int          stale;           // responses owed to requests from before a flush.
    int          occupancy;       // words held in the queue.
    logic        first_req_seen;

    frontend_top u_dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .flush           (flush),
        .redirect_pc     (redirect_pc),
        .deq             (deq),
        .inst_valid      (inst_valid),
        .inst_pc         (inst_pc),
        .inst_data       (inst_data),
        .imem_req        (imem_req),
        .imem_addr       (imem_addr),
        .imem_resp_valid (imem_resp_valid),
        .imem_resp_data  (imem_resp_data)
    );

    imem_model u_imem (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (imem_req),
        .addr       (imem_addr),
        .resp_valid (imem_resp_valid),
        .resp_data  (imem_resp_data)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s at %0t", what, $time);
    endtask

    // reference model of the fetch stream, updated at every rising edge.
    always @(posedge clk) begin
        if (!arst_n) begin
            check_value("inst_valid", 32'(inst_valid), 32'h0);
            check_value("imem_req", 32'(imem_req), 32'h0);
        end else begin
            if (imem_req) begin
                if (!first_req_seen) begin
                    check_value("imem_addr", imem_addr, frontend_pkg::reset_vector);
                    first_req_seen = 1'b1;
                end
                if (flush) begin
                    report_failure("memory request issued in a flush cycle");
                end
            end
            check_value("inst_valid", 32'(inst_valid), 32'(occupancy != 0));

            if (deq && inst_valid) begin
                check_value("inst_pc", inst_pc, exp_pc);
                check_value("inst_data", inst_data, ~exp_pc);
                exp_pc = exp_pc + 32'd4;
                words_checked++;
            end

            if (flush) begin
                // an answer arriving right now is dropped with the rest.
                stale     = outstanding - int'(imem_resp_valid);
                occupancy = 0;
                exp_pc    = redirect_pc;
                flushes++;
            end else begin
                if (imem_resp_valid) begin
                    if (stale > 0) begin
                        stale--;
                    end else begin
                        occupancy++;
                    end
                end
                if (deq && inst_valid) begin
                    occupancy--;
                end
            end

            outstanding = outstanding + int'(imem_req) - int'(imem_resp_valid);
            if (outstanding > frontend_pkg::max_outstanding) begin
                report_failure($sformatf("%0d memory requests outstanding", outstanding));
            end
            if (occupancy > frontend_pkg::queue_depth) begin
                report_failure($sformatf("queue would hold %0d words", occupancy));
            end
        end
    end

    task automatic wait_for_valid(input int limit, input string what);
        int n;
        n = 0;
        while (!inst_valid && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!inst_valid) begin
            report_failure($sformatf("timeout waiting for %s", what));
        end
    endtask

    task automatic run_random(input int cycles, input int deq_pct);
        repeat (cycles) begin
            @(negedge clk);
            flush = (($urandom % 60) == 0);
            if (flush) begin
                redirect_pc = $urandom & 32'hffff_fffc;  // word aligned.
            end
            deq = (($urandom % 100) < deq_pct);
        end
    endtask

    // hold deq low until the queue is full, then make sure fetch stays quiet.
    task automatic stall_until_full(input int limit);
        int n;
        @(negedge clk);
        flush = 1'b0;
        deq   = 1'b0;
        n = 0;
        while (occupancy != frontend_pkg::queue_depth && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (occupancy != frontend_pkg::queue_depth) begin
            report_failure("timeout waiting for the queue to fill");
        end
        repeat (20) begin
            @(negedge clk);
            check_value("imem_req", 32'(imem_req), 32'h0);
        end
    endtask

    task automatic drain_words(input int words, input int limit);
        int n;
        int target;
        target = words_checked + words;
        n = 0;
        @(negedge clk);
        flush = 1'b0;
        deq   = 1'b1;
        while (words_checked < target && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (words_checked < target) begin
            report_failure("timeout waiting for the stream to resume");
        end
    endtask

    initial begin
        void'($urandom(91));
        clk            = 1'b0;
        arst_n         = 1'b0;
        flush          = 1'b0;
        redirect_pc    = '0;
        deq            = 1'b0;
        errors         = 0;
        words_checked  = 0;
        flushes        = 0;
        exp_pc         = frontend_pkg::reset_vector;
        outstanding    = 0;
        stale          = 0;
        occupancy      = 0;
        first_req_seen = 1'b0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        deq    = 1'b1;  // dequeue against an empty queue first.

        wait_for_valid(40, "the first fetched word");
        run_random(500, 80);
        run_random(200, 5);
        run_random(400, 50);
        run_random(150, 0);
        stall_until_full(200);
        drain_words(40, 400);
        run_random(500, 95);
        run_random(300, 30);
        stall_until_full(200);
        drain_words(40, 400);

        @(negedge clk);
        deq = 1'b0;
        repeat (4) @(negedge clk);

        $display("errors %0d, words checked %0d, flushes %0d",
                 errors, words_checked, flushes);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
